// ==== Bender.yml ====
package:
  name: id_stage

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/id_pkg.sv
      - rtl/regfile.sv
      - rtl/inst_decoder.sv
      - rtl/operand_bypass.sv
      - rtl/branch_unit.sv
      - rtl/id_ex_reg.sv
      - rtl/id_stage.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - bench/tb_id_stage.sv

// ==== bench/tb_id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module tb_id_stage;

  logic                clk;
  logic                arst_n_i;
  logic                inst_valid_i;
  logic [`XLEN-1:0]    pc_i;
  logic [`INST_W-1:0]  inst_i;
  id_pkg::ex_fwd_t     ex_fwd_i;
  id_pkg::wr_port_t    mem_fwd_i;
  id_pkg::wr_port_t    wb_i;
  logic                stall_i;
  id_pkg::id_ex_t      ex_o;
  id_pkg::branch_t     branch_o;
  logic                stall_o;

  localparam logic [16:0] OP_ADD = 17'h20;
  localparam logic [5:0]  OP_BEQ = 6'b010110;

  logic [31:0]      lfsr;
  logic [`XLEN-1:0] regs_m [`NUM_REGS];
  id_pkg::branch_t  br_seen;
  logic             stall_seen;
  logic [`XLEN-1:0] pc_issued;
  logic [5:0]       br_ops [6] = '{6'b010110, 6'b010111, 6'b011000,
                                   6'b011001, 6'b011010, 6'b011011};

  id_stage u_id_stage (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .inst_valid_i (inst_valid_i),
    .pc_i         (pc_i),
    .inst_i       (inst_i),
    .ex_fwd_i     (ex_fwd_i),
    .mem_fwd_i    (mem_fwd_i),
    .wb_i         (wb_i),
    .stall_i      (stall_i),
    .ex_o         (ex_o),
    .branch_o     (branch_o),
    .stall_o      (stall_o)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Galois LFSR, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++)
    begin
      val  = {val[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BC_D35C) : (lfsr >> 1);
    end
    return val;
  endfunction

  function automatic logic [31:0] enc_3r(input logic [16:0] op17, input logic [4:0] rk,
                                         input logic [4:0] rj, input logic [4:0] rd);
    return {op17, rk, rj, rd};
  endfunction

  function automatic logic [31:0] enc_2ri12(input logic [9:0] op10, input logic [11:0] imm,
                                            input logic [4:0] rj, input logic [4:0] rd);
    return {op10, imm, rj, rd};
  endfunction

  function automatic logic [31:0] enc_1ri20(input logic [6:0] op7, input logic [19:0] imm,
                                            input logic [4:0] rd);
    return {op7, imm, rd};
  endfunction

  function automatic logic [31:0] enc_2ri16(input logic [5:0] op6, input logic [15:0] offs,
                                            input logic [4:0] rj, input logic [4:0] rd);
    return {op6, offs, rj, rd};
  endfunction

  // Upper ten offset bits sit in the low field
  function automatic logic [31:0] enc_i26(input logic [5:0] op6, input logic [25:0] offs);
    return {op6, offs[15:0], offs[25:16]};
  endfunction

  function automatic logic [31:0] sx12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] br_off16(input logic [15:0] v);
    return {{14{v[15]}}, v, 2'b00};
  endfunction

  function automatic logic [31:0] br_off26(input logic [25:0] v);
    return {{4{v[25]}}, v, 2'b00};
  endfunction

  function automatic logic ref_taken(input logic [5:0] op6, input logic [31:0] a,
                                     input logic [31:0] b);
    case (op6)
      6'b010110: return a == b;
      6'b010111: return a != b;
      6'b011000: return $signed(a) < $signed(b);
      6'b011001: return $signed(a) >= $signed(b);
      6'b011010: return a < b;
      6'b011011: return a >= b;
      default:   return 1'b1;
    endcase
  endfunction

  function automatic id_pkg::wr_port_t make_wr(input logic we, input logic [4:0] a,
                                               input logic [31:0] d);
    return {we, a, d};
  endfunction

  function automatic id_pkg::ex_fwd_t make_exf(input logic we, input logic [4:0] a,
                                               input logic [31:0] d, input logic ld);
    return {we, a, d, ld};
  endfunction

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1);
  endtask

  task automatic check(input logic ok, input string what);
    assert (ok)
    else
    begin
      $display("FAIL at %0t ns: %s", $time, what);
      abort_run();
    end
  endtask

  // Present one instruction; ex_o is sampled after the capture edge
  task automatic issue(input logic valid, input logic [31:0] inst, input logic [31:0] pc,
                       input id_pkg::ex_fwd_t exf, input id_pkg::wr_port_t memf,
                       input id_pkg::wr_port_t wb, input logic hold);
    @(posedge clk);
    inst_valid_i <= valid;
    inst_i       <= inst;
    pc_i         <= pc;
    ex_fwd_i     <= exf;
    mem_fwd_i    <= memf;
    wb_i         <= wb;
    stall_i      <= hold;
    pc_issued    = pc;
    @(negedge clk);
    br_seen    = branch_o;
    stall_seen = stall_o;
    @(posedge clk);
    if (wb.we && wb.waddr != '0)
      regs_m[wb.waddr] = wb.wdata;
    @(negedge clk);
  endtask

  task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
    issue(1'b0, '0, '0, '0, '0, make_wr(1'b1, a, d), 1'b0);
  endtask

  task automatic wait_stall_clear(input int max_cycles);
    int n;
    n = 0;
    @(negedge clk);
    while (stall_o !== 1'b0)
    begin
      if (n == max_cycles)
      begin
        $display("Timed out waiting for stall_o to drop");
        abort_run();
      end
      n++;
      @(negedge clk);
    end
  endtask

  task automatic check_ex(input string name, input id_pkg::alu_op_e op,
                          input id_pkg::alu_sel_e sel, input logic [31:0] op1,
                          input logic [31:0] op2, input logic [4:0] waddr, input logic we);
    check(ex_o.valid === 1'b1, $sformatf("%s: ex_o.valid is %b", name, ex_o.valid));
    check(ex_o.pc === pc_issued,
          $sformatf("%s: pc %h, expected %h", name, ex_o.pc, pc_issued));
    check(ex_o.alu_op === op && ex_o.alu_sel === sel,
          $sformatf("%s: alu_op/alu_sel %0d/%0d, expected %0d/%0d", name,
                    ex_o.alu_op, ex_o.alu_sel, op, sel));
    check(ex_o.op1 === op1, $sformatf("%s: op1 %h, expected %h", name, ex_o.op1, op1));
    check(ex_o.op2 === op2, $sformatf("%s: op2 %h, expected %h", name, ex_o.op2, op2));
    check(ex_o.we === we && ex_o.waddr === waddr,
          $sformatf("%s: we/waddr %b/%0d, expected %b/%0d", name,
                    ex_o.we, ex_o.waddr, we, waddr));
  endtask

  task automatic reset_values();
    check(ex_o.valid === 1'b0, "ex_o.valid high after reset");
    check(branch_o.taken === 1'b0, "branch_o.taken high after reset");
    check(stall_o === 1'b0, "stall_o high after reset");
    issue(1'b1, enc_3r(OP_ADD, 5'd4, 5'd3, 5'd2), 32'h100, '0, '0, '0, 1'b0);
    check_ex("add.w after reset", id_pkg::ALU_ADD, id_pkg::SEL_ARITH, '0, '0, 5'd2, 1'b1);
  endtask

  task automatic rr_one(input string name, input logic [6:0] op7, input id_pkg::alu_op_e op,
                        input id_pkg::alu_sel_e sel, input logic [4:0] rd);
    logic [4:0] rj;
    logic [4:0] rk;
    rj = 5'(rand_bits(5));
    rk = 5'(rand_bits(5));
    issue(1'b1, enc_3r({10'b0, op7}, rk, rj, rd), 32'h1000, '0, '0, '0, 1'b0);
    check_ex(name, op, sel, regs_m[rj], regs_m[rk], rd, rd != 5'd0);
  endtask

  task automatic reg_reg_ops();
    for (int r = 1; r < `NUM_REGS; r++)
      write_reg(5'(r), rand_bits(32));
    rr_one("add.w", 7'h20, id_pkg::ALU_ADD, id_pkg::SEL_ARITH, 5'(rand_bits(5)));
    rr_one("sub.w", 7'h22, id_pkg::ALU_SUB, id_pkg::SEL_ARITH, 5'(rand_bits(5)));
    rr_one("slt", 7'h24, id_pkg::ALU_SLT, id_pkg::SEL_ARITH, 5'(rand_bits(5)));
    rr_one("sltu", 7'h25, id_pkg::ALU_SLTU, id_pkg::SEL_ARITH, 5'(rand_bits(5)));
    rr_one("nor", 7'h28, id_pkg::ALU_NOR, id_pkg::SEL_LOGIC, 5'(rand_bits(5)));
    rr_one("and", 7'h29, id_pkg::ALU_AND, id_pkg::SEL_LOGIC, 5'(rand_bits(5)));
    rr_one("or", 7'h2a, id_pkg::ALU_OR, id_pkg::SEL_LOGIC, 5'(rand_bits(5)));
    rr_one("xor", 7'h2b, id_pkg::ALU_XOR, id_pkg::SEL_LOGIC, 5'(rand_bits(5)));
    rr_one("sll.w", 7'h2e, id_pkg::ALU_SLL, id_pkg::SEL_SHIFT, 5'(rand_bits(5)));
    rr_one("srl.w", 7'h2f, id_pkg::ALU_SRL, id_pkg::SEL_SHIFT, 5'(rand_bits(5)));
    rr_one("sra.w", 7'h30, id_pkg::ALU_SRA, id_pkg::SEL_SHIFT, 5'(rand_bits(5)));
    rr_one("add.w to r0", 7'h20, id_pkg::ALU_ADD, id_pkg::SEL_ARITH, 5'd0);
  endtask

  // Bit 11 set so sign and zero extension differ
  task automatic imm_one(input string name, input logic [9:0] op10, input id_pkg::alu_op_e op,
                         input id_pkg::alu_sel_e sel, input logic sign_ext);
    logic [11:0] imm;
    logic [4:0]  rj;
    logic [4:0]  rd;
    imm = 12'h800 | 12'(rand_bits(11));
    rj  = 5'(rand_bits(5));
    rd  = 5'(rand_bits(5));
    issue(1'b1, enc_2ri12(op10, imm, rj, rd), 32'h2000, '0, '0, '0, 1'b0);
    check_ex(name, op, sel, regs_m[rj], sign_ext ? sx12(imm) : {20'b0, imm}, rd, rd != 5'd0);
  endtask

  task automatic shift_one(input string name, input logic [6:0] op7, input id_pkg::alu_op_e op);
    logic [4:0] ui5;
    logic [4:0] rj;
    logic [4:0] rd;
    ui5 = 5'(rand_bits(5));
    rj  = 5'(rand_bits(5));
    rd  = 5'(rand_bits(5));
    issue(1'b1, enc_3r({10'b1, op7}, ui5, rj, rd), 32'h2100, '0, '0, '0, 1'b0);
    check_ex(name, op, id_pkg::SEL_SHIFT, regs_m[rj], {27'b0, ui5}, rd, rd != 5'd0);
  endtask

  task automatic imm_forms();
    logic [19:0] si20;
    logic [11:0] offs;
    logic [31:0] pc;
    imm_one("addi.w", 10'b0000001010, id_pkg::ALU_ADD, id_pkg::SEL_ARITH, 1'b1);
    imm_one("slti", 10'b0000001000, id_pkg::ALU_SLT, id_pkg::SEL_ARITH, 1'b1);
    imm_one("sltui", 10'b0000001001, id_pkg::ALU_SLTU, id_pkg::SEL_ARITH, 1'b1);
    imm_one("andi", 10'b0000001101, id_pkg::ALU_AND, id_pkg::SEL_LOGIC, 1'b0);
    imm_one("ori", 10'b0000001110, id_pkg::ALU_OR, id_pkg::SEL_LOGIC, 1'b0);
    imm_one("xori", 10'b0000001111, id_pkg::ALU_XOR, id_pkg::SEL_LOGIC, 1'b0);
    imm_one("ld.w", 10'b0010100010, id_pkg::ALU_LD_W, id_pkg::SEL_LOAD_STORE, 1'b1);
    shift_one("slli.w", 7'h01, id_pkg::ALU_SLL);
    shift_one("srli.w", 7'h09, id_pkg::ALU_SRL);
    shift_one("srai.w", 7'h11, id_pkg::ALU_SRA);
    si20 = 20'(rand_bits(20));
    pc   = rand_bits(32) & 32'hffff_fffc;
    issue(1'b1, enc_1ri20(7'b0001010, si20, 5'd9), pc, '0, '0, '0, 1'b0);
    check_ex("lu12i.w", id_pkg::ALU_LUI, id_pkg::SEL_MOVE, '0, {si20, 12'b0}, 5'd9, 1'b1);
    issue(1'b1, enc_1ri20(7'b0001110, si20, 5'd9), pc, '0, '0, '0, 1'b0);
    check_ex("pcaddu12i", id_pkg::ALU_PCADD, id_pkg::SEL_MOVE, pc, {si20, 12'b0}, 5'd9, 1'b1);
    // st.w takes its data from rd
    offs = 12'h800 | 12'(rand_bits(11));
    issue(1'b1, enc_2ri12(10'b0010100110, offs, 5'd7, 5'd8), 32'h2200, '0, '0, '0, 1'b0);
    check_ex("st.w", id_pkg::ALU_ST_W, id_pkg::SEL_LOAD_STORE, regs_m[7], sx12(offs), 5'd8,
             1'b0);
    check(ex_o.st_data === regs_m[8],
          $sformatf("st.w: st_data %h, expected %h", ex_o.st_data, regs_m[8]));
  endtask

  task automatic forward_priority();
    logic [31:0] e;
    logic [31:0] m;
    logic [31:0] w;
    e = rand_bits(32);
    m = rand_bits(32);
    w = rand_bits(32);
    issue(1'b1, enc_3r(OP_ADD, 5'd10, 5'd10, 5'd13), 32'h3000, make_exf(1'b1, 5'd10, e, 1'b0),
          make_wr(1'b1, 5'd10, m), make_wr(1'b1, 5'd10, w), 1'b0);
    check_ex("ex over mem", id_pkg::ALU_ADD, id_pkg::SEL_ARITH, e, e, 5'd13, 1'b1);
    e = rand_bits(32);
    m = rand_bits(32);
    w = rand_bits(32);
    issue(1'b1, enc_3r(OP_ADD, 5'd11, 5'd10, 5'd13), 32'h3000, make_exf(1'b1, 5'd12, e, 1'b0),
          make_wr(1'b1, 5'd10, m), make_wr(1'b1, 5'd11, w), 1'b0);
    check_ex("mem over regfile", id_pkg::ALU_ADD, id_pkg::SEL_ARITH, m, w, 5'd13, 1'b1);
    w = rand_bits(32);
    issue(1'b1, enc_3r(OP_ADD, 5'd11, 5'd10, 5'd13), 32'h3000, '0, '0,
          make_wr(1'b1, 5'd10, w), 1'b0);
    check_ex("same-cycle writeback", id_pkg::ALU_ADD, id_pkg::SEL_ARITH, w, regs_m[11], 5'd13,
             1'b1);
  endtask

  task automatic load_use_stall();
    logic [31:0]    inst;
    id_pkg::id_ex_t snap;
    inst = enc_3r(OP_ADD, 5'd11, 5'd10, 5'd13);
    issue(1'b1, inst, 32'h4000, make_exf(1'b1, 5'd10, rand_bits(32), 1'b1), '0, '0, 1'b0);
    check(stall_seen === 1'b1, "stall_o low with a load on rs1");
    check(ex_o.valid === 1'b0 && ex_o.we === 1'b0, "no bubble after a load-use hazard");
    @(posedge clk);
    ex_fwd_i <= '0;
    wait_stall_clear(8);
    issue(1'b1, inst, 32'h4000, '0, '0, '0, 1'b0);
    check_ex("re-presented add.w", id_pkg::ALU_ADD, id_pkg::SEL_ARITH, regs_m[10], regs_m[11],
             5'd13, 1'b1);
    issue(1'b1, inst, 32'h4000, make_exf(1'b1, 5'd11, rand_bits(32), 1'b1), '0, '0, 1'b0);
    check(stall_seen === 1'b1, "stall_o low with a load on rs2");
    issue(1'b1, inst, 32'h4000, make_exf(1'b0, 5'd10, rand_bits(32), 1'b0), '0, '0, 1'b0);
    check(stall_seen === 1'b0, "stall_o high with a store in execute");
    issue(1'b1, inst, 32'h4000, make_exf(1'b1, 5'd12, rand_bits(32), 1'b1), '0, '0, 1'b0);
    check(stall_seen === 1'b0, "stall_o high with a load to another register");
    check_ex("unrelated load", id_pkg::ALU_ADD, id_pkg::SEL_ARITH, regs_m[10], regs_m[11],
             5'd13, 1'b1);
    issue(1'b1, enc_2ri16(OP_BEQ, 16'h0010, 5'd10, 5'd10), 32'h4000,
          make_exf(1'b1, 5'd10, rand_bits(32), 1'b1), '0, '0, 1'b0);
    check(stall_seen === 1'b1 && br_seen.taken === 1'b0, "branch taken during load-use stall");
    // ex_o must keep the older instruction under stall_i
    issue(1'b1, inst, 32'h4000, '0, '0, '0, 1'b0);
    snap = ex_o;
    issue(1'b1, enc_3r(17'h22, 5'd3, 5'd4, 5'd5), 32'h4004, '0, '0, '0, 1'b1);
    check(ex_o === snap, "ex_o changed while stall_i was high");
  endtask

  task automatic br_one(input logic [5:0] op6, input logic [31:0] a, input logic [31:0] b);
    logic [15:0] offs;
    logic [31:0] pc;
    offs = 16'(rand_bits(16));
    pc   = rand_bits(32) & 32'hffff_fffc;
    write_reg(5'd5, a);
    write_reg(5'd6, b);
    issue(1'b1, enc_2ri16(op6, offs, 5'd5, 5'd6), pc, '0, '0, '0, 1'b0);
    check(br_seen.taken === ref_taken(op6, a, b),
          $sformatf("branch %b a=%h b=%h: taken %b", op6, a, b, br_seen.taken));
    check(br_seen.target === pc + br_off16(offs),
          $sformatf("branch %b: target %h, expected %h", op6, br_seen.target,
                    pc + br_off16(offs)));
    check_ex("conditional branch", id_pkg::ALU_JUMP, id_pkg::SEL_JUMP, pc + `INST_BYTES, '0,
             5'd6, 1'b0);
  endtask

  task automatic branch_cases();
    logic [31:0] a;
    logic [31:0] pc;
    logic [25:0] off26;
    logic [15:0] offs;
    for (int i = 0; i < 6; i++)
    begin
      a = rand_bits(32);
      br_one(br_ops[i], a, rand_bits(32));
      br_one(br_ops[i], a, a);
      br_one(br_ops[i], 32'h8000_0000, 32'h7fff_ffff);
      br_one(br_ops[i], 32'h7fff_ffff, 32'h8000_0000);
      br_one(br_ops[i], 32'hffff_ffff, 32'h0000_0001);
    end
    for (int k = 0; k < 2; k++)
    begin
      pc    = rand_bits(32) & 32'hffff_fffc;
      off26 = 26'(rand_bits(26));
      issue(1'b1, enc_i26(k == 0 ? 6'b010100 : 6'b010101, off26), pc, '0, '0, '0, 1'b0);
      check(br_seen.taken === 1'b1, "b or bl not taken");
      check(br_seen.target === pc + br_off26(off26),
            $sformatf("b/bl: target %h, expected %h", br_seen.target, pc + br_off26(off26)));
      check_ex(k == 0 ? "b" : "bl", id_pkg::ALU_JUMP, id_pkg::SEL_JUMP, pc + `INST_BYTES, '0,
               5'(`LINK_REG), k == 1);
    end
    a    = rand_bits(32);
    offs = 16'(rand_bits(16));
    pc   = rand_bits(32) & 32'hffff_fffc;
    write_reg(5'd5, a);
    issue(1'b1, enc_2ri16(6'b010011, offs, 5'd5, 5'd7), pc, '0, '0, '0, 1'b0);
    check(br_seen.taken === 1'b1 && br_seen.target === a + br_off16(offs),
          $sformatf("jirl: target %h, expected %h", br_seen.target, a + br_off16(offs)));
    check_ex("jirl", id_pkg::ALU_JUMP, id_pkg::SEL_JUMP, pc + `INST_BYTES, '0, 5'd7, 1'b1);
    issue(1'b0, enc_2ri16(OP_BEQ, offs, 5'd5, 5'd5), pc, '0, '0, '0, 1'b0);
    check(br_seen.taken === 1'b0, "branch taken without inst_valid_i");
    check(ex_o.valid === 1'b0, "ex_o.valid high without inst_valid_i");
  endtask

  initial
  begin
    lfsr         = 32'd5531;
    arst_n_i     = 1'b0;
    inst_valid_i = 1'b0;
    pc_i         = '0;
    inst_i       = '0;
    ex_fwd_i     = '0;
    mem_fwd_i    = '0;
    wb_i         = '0;
    stall_i      = 1'b0;
    for (int r = 0; r < `NUM_REGS; r++)
      regs_m[r] = '0;
    repeat (5) @(posedge clk);
    arst_n_i <= 1'b1;
    @(negedge clk);
    reset_values();
    reg_reg_ops();
    imm_forms();
    forward_priority();
    load_use_stall();
    branch_cases();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module branch_unit (
  input  id_pkg::dec_t      dec_i,
  input  logic [`XLEN-1:0]  pc_i,
  input  logic [`XLEN-1:0]  src1_i,
  input  logic [`XLEN-1:0]  src2_i,
  input  logic              inst_valid_i,
  input  logic              hazard_i,
  output id_pkg::branch_t   branch_o,
  output logic [`XLEN-1:0]  link_o
);

  logic             eq;
  logic             lt;
  logic             ltu;
  logic             cond;
  logic [`XLEN-1:0] base;

  assign eq  = (src1_i == src2_i);
  assign lt  = ($signed(src1_i) < $signed(src2_i));
  assign ltu = (src1_i < src2_i);

  always_comb
  begin
    case (dec_i.br_cond)
      id_pkg::BR_EQ:      cond = eq;
      id_pkg::BR_NE:      cond = !eq;
      id_pkg::BR_LT:      cond = lt;
      id_pkg::BR_GE:      cond = !lt;
      id_pkg::BR_LTU:     cond = ltu;
      id_pkg::BR_GEU:     cond = !ltu;
      id_pkg::BR_PC_REL:  cond = 1'b1;
      id_pkg::BR_REG_REL: cond = 1'b1;
      default:            cond = 1'b0;
    endcase
  end

  // jirl jumps relative to rj
  assign base = (dec_i.br_cond == id_pkg::BR_REG_REL) ? src1_i : pc_i;

  assign branch_o.target = base + dec_i.br_offset;
  // Wait for the load-use stall to clear before redirecting
  assign branch_o.taken  = cond && inst_valid_i && !hazard_i;

  assign link_o = pc_i + `XLEN'(`INST_BYTES);

endmodule

`default_nettype wire

// ==== rtl/id_defs.svh ====
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// Data and address width
`define XLEN 32

// Instruction word width
`define INST_W 32

// Register file geometry
`define REG_AW 5
`define NUM_REGS 32

// Return address register written by bl
`define LINK_REG 1

// Sequential instruction stride
`define INST_BYTES 4

`endif

// ==== rtl/id_ex_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_ex_reg (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              stall_i,
  input  logic              hazard_i,
  input  logic              inst_valid_i,
  input  logic [`XLEN-1:0]  pc_i,
  input  id_pkg::dec_t      dec_i,
  input  logic [`XLEN-1:0]  src1_i,
  input  logic [`XLEN-1:0]  src2_i,
  input  logic [`XLEN-1:0]  link_i,
  output id_pkg::id_ex_t    ex_o
);

  id_pkg::id_ex_t ex_d;
  id_pkg::id_ex_t ex_q;
  logic           is_jump;
  logic           is_store;

  assign is_jump  = (dec_i.alu_sel == id_pkg::SEL_JUMP);
  assign is_store = (dec_i.alu_op == id_pkg::ALU_ST_W);

  always_comb
  begin
    ex_d.valid   = inst_valid_i && !hazard_i;
    ex_d.pc      = pc_i;
    ex_d.alu_op  = dec_i.alu_op;
    ex_d.alu_sel = dec_i.alu_sel;
    ex_d.waddr   = dec_i.waddr;
    ex_d.we      = dec_i.we && ex_d.valid;
    ex_d.st_data = is_store ? src2_i : '0;

    // Jumps pass the link address through the adder
    if (is_jump)
      ex_d.op1 = link_i;
    else if (dec_i.alu_op == id_pkg::ALU_PCADD)
      ex_d.op1 = pc_i;
    else if (dec_i.alu_op == id_pkg::ALU_LUI)
      ex_d.op1 = '0;
    else
      ex_d.op1 = src1_i;

    if (is_jump)
      ex_d.op2 = '0;
    else if (dec_i.rs2_rd && !is_store)
      ex_d.op2 = src2_i;
    else
      ex_d.op2 = dec_i.imm;
  end

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
      ex_q <= '0;
    else if (!stall_i)
      ex_q <= ex_d;
  end

  assign ex_o = ex_q;

  a_we_not_r0: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    ex_o.we |-> (ex_o.waddr != '0)
  ) else $error("register write to r0 in the payload");

endmodule

`default_nettype wire

// ==== rtl/id_pkg.sv ====
`default_nettype none

`include "id_defs.svh"

package id_pkg;

  // Operation handed to execute
  typedef enum logic [4:0] {
    ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
    ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_LUI, ALU_PCADD, ALU_LD_W, ALU_ST_W, ALU_JUMP
  } alu_op_e;

  // Result class for the execute mux
  typedef enum logic [2:0] {
    SEL_NOP, SEL_LOGIC, SEL_SHIFT, SEL_ARITH, SEL_MOVE, SEL_LOAD_STORE, SEL_JUMP
  } alu_sel_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE, BR_LTU, BR_GEU, BR_PC_REL, BR_REG_REL
  } br_cond_e;

  typedef struct packed {
    alu_op_e            alu_op;
    alu_sel_e           alu_sel;
    logic [`REG_AW-1:0] rs1_addr;
    logic [`REG_AW-1:0] rs2_addr;
    logic               rs1_rd;
    logic               rs2_rd;
    logic [`REG_AW-1:0] waddr;
    logic               we;
    logic               is_load;
    br_cond_e           br_cond;
    logic [`XLEN-1:0]   imm;
    logic [`XLEN-1:0]   br_offset;
  } dec_t;

  typedef struct packed {
    logic               we;
    logic [`REG_AW-1:0] waddr;
    logic [`XLEN-1:0]   wdata;
  } wr_port_t;

  // Execute result, tagged when its data arrives only after memory
  typedef struct packed {
    wr_port_t wr;
    logic     is_load;
  } ex_fwd_t;

  typedef struct packed {
    logic             taken;
    logic [`XLEN-1:0] target;
  } branch_t;

  typedef struct packed {
    logic               valid;
    logic [`XLEN-1:0]   pc;
    alu_op_e            alu_op;
    alu_sel_e           alu_sel;
    logic [`XLEN-1:0]   op1;
    logic [`XLEN-1:0]   op2;
    logic [`XLEN-1:0]   st_data;
    logic [`REG_AW-1:0] waddr;
    logic               we;
  } id_ex_t;

endpackage

`default_nettype wire

// ==== rtl/id_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module id_stage (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              inst_valid_i,
  input  logic [`XLEN-1:0]  pc_i,
  input  logic [`INST_W-1:0] inst_i,
  input  id_pkg::ex_fwd_t   ex_fwd_i,
  input  id_pkg::wr_port_t  mem_fwd_i,
  input  id_pkg::wr_port_t  wb_i,
  input  logic              stall_i,
  output id_pkg::id_ex_t    ex_o,
  output id_pkg::branch_t   branch_o,
  output logic              stall_o
);

  id_pkg::dec_t     dec;
  logic [`XLEN-1:0] rdata1;
  logic [`XLEN-1:0] rdata2;
  logic [`XLEN-1:0] src1;
  logic [`XLEN-1:0] src2;
  logic [`XLEN-1:0] link;
  logic             hazard;

  inst_decoder u_inst_decoder (
    .inst_i (inst_i),
    .dec_o  (dec)
  );

  regfile u_regfile (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .wb_i     (wb_i),
    .raddr1_i (dec.rs1_addr),
    .raddr2_i (dec.rs2_addr),
    .rdata1_o (rdata1),
    .rdata2_o (rdata2)
  );

  operand_bypass u_operand_bypass (
    .dec_i        (dec),
    .rdata1_i     (rdata1),
    .rdata2_i     (rdata2),
    .ex_fwd_i     (ex_fwd_i),
    .mem_fwd_i    (mem_fwd_i),
    .inst_valid_i (inst_valid_i),
    .src1_o       (src1),
    .src2_o       (src2),
    .hazard_o     (hazard)
  );

  branch_unit u_branch_unit (
    .dec_i        (dec),
    .pc_i         (pc_i),
    .src1_i       (src1),
    .src2_i       (src2),
    .inst_valid_i (inst_valid_i),
    .hazard_i     (hazard),
    .branch_o     (branch_o),
    .link_o       (link)
  );

  id_ex_reg u_id_ex_reg (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .stall_i      (stall_i),
    .hazard_i     (hazard),
    .inst_valid_i (inst_valid_i),
    .pc_i         (pc_i),
    .dec_i        (dec),
    .src1_i       (src1),
    .src2_i       (src2),
    .link_i       (link),
    .ex_o         (ex_o)
  );

  assign stall_o = hazard;

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module inst_decoder (
  input  logic [`INST_W-1:0] inst_i,
  output id_pkg::dec_t       dec_o
);

  logic [`REG_AW-1:0] rd;
  logic [`REG_AW-1:0] rj;
  logic [`REG_AW-1:0] rk;
  logic [`XLEN-1:0]   si12;
  logic [`XLEN-1:0]   ui12;
  logic [`XLEN-1:0]   ui5;
  logic [`XLEN-1:0]   si20;
  logic [`XLEN-1:0]   offs16;
  logic [`XLEN-1:0]   offs26;

  assign rd = inst_i[4:0];
  assign rj = inst_i[9:5];
  assign rk = inst_i[14:10];

  assign si12   = {{(`XLEN-12){inst_i[21]}}, inst_i[21:10]};
  assign ui12   = {{(`XLEN-12){1'b0}}, inst_i[21:10]};
  assign ui5    = {{(`XLEN-5){1'b0}}, inst_i[14:10]};
  assign si20   = {inst_i[24:5], 12'b0};
  assign offs16 = {{(`XLEN-18){inst_i[25]}}, inst_i[25:10], 2'b00};
  // b and bl keep the upper offset bits in the rj and rd fields
  assign offs26 = {{(`XLEN-28){inst_i[9]}}, inst_i[9:0], inst_i[25:10], 2'b00};

  function automatic id_pkg::alu_sel_e sel_of(input id_pkg::alu_op_e op);
    case (op)
      id_pkg::ALU_ADD, id_pkg::ALU_SUB, id_pkg::ALU_SLT, id_pkg::ALU_SLTU:
        return id_pkg::SEL_ARITH;
      id_pkg::ALU_AND, id_pkg::ALU_OR, id_pkg::ALU_NOR, id_pkg::ALU_XOR:
        return id_pkg::SEL_LOGIC;
      id_pkg::ALU_SLL, id_pkg::ALU_SRL, id_pkg::ALU_SRA:
        return id_pkg::SEL_SHIFT;
      id_pkg::ALU_LUI, id_pkg::ALU_PCADD:
        return id_pkg::SEL_MOVE;
      id_pkg::ALU_LD_W, id_pkg::ALU_ST_W:
        return id_pkg::SEL_LOAD_STORE;
      id_pkg::ALU_JUMP:
        return id_pkg::SEL_JUMP;
      default:
        return id_pkg::SEL_NOP;
    endcase
  endfunction

  always_comb
  begin
    dec_o           = '0;
    dec_o.rs1_addr  = rj;
    dec_o.rs2_addr  = rk;
    dec_o.waddr     = rd;
    dec_o.br_offset = offs16;
    case (inst_i[31:26])
      6'b000000:
      begin
        case (inst_i[25:22])
          // Three-register ops
          4'b0000:
          begin
            case (inst_i[21:15])
              7'h20: dec_o.alu_op = id_pkg::ALU_ADD;
              7'h22: dec_o.alu_op = id_pkg::ALU_SUB;
              7'h24: dec_o.alu_op = id_pkg::ALU_SLT;
              7'h25: dec_o.alu_op = id_pkg::ALU_SLTU;
              7'h28: dec_o.alu_op = id_pkg::ALU_NOR;
              7'h29: dec_o.alu_op = id_pkg::ALU_AND;
              7'h2a: dec_o.alu_op = id_pkg::ALU_OR;
              7'h2b: dec_o.alu_op = id_pkg::ALU_XOR;
              7'h2e: dec_o.alu_op = id_pkg::ALU_SLL;
              7'h2f: dec_o.alu_op = id_pkg::ALU_SRL;
              7'h30: dec_o.alu_op = id_pkg::ALU_SRA;
              default: dec_o.alu_op = id_pkg::ALU_NOP;
            endcase
          end
          // Shift by ui5
          4'b0001:
          begin
            dec_o.imm = ui5;
            case (inst_i[21:15])
              7'h01: dec_o.alu_op = id_pkg::ALU_SLL;
              7'h09: dec_o.alu_op = id_pkg::ALU_SRL;
              7'h11: dec_o.alu_op = id_pkg::ALU_SRA;
              default: dec_o.alu_op = id_pkg::ALU_NOP;
            endcase
          end
          4'b1000:
          begin
            dec_o.alu_op = id_pkg::ALU_SLT;
            dec_o.imm    = si12;
          end
          4'b1001:
          begin
            dec_o.alu_op = id_pkg::ALU_SLTU;
            dec_o.imm    = si12;
          end
          4'b1010:
          begin
            dec_o.alu_op = id_pkg::ALU_ADD;
            dec_o.imm    = si12;
          end
          // Logical immediates are zero extended
          4'b1101:
          begin
            dec_o.alu_op = id_pkg::ALU_AND;
            dec_o.imm    = ui12;
          end
          4'b1110:
          begin
            dec_o.alu_op = id_pkg::ALU_OR;
            dec_o.imm    = ui12;
          end
          4'b1111:
          begin
            dec_o.alu_op = id_pkg::ALU_XOR;
            dec_o.imm    = ui12;
          end
          default: dec_o.alu_op = id_pkg::ALU_NOP;
        endcase
        dec_o.rs1_rd = (dec_o.alu_op != id_pkg::ALU_NOP);
        dec_o.rs2_rd = dec_o.rs1_rd && (inst_i[25:22] == 4'b0000);
        dec_o.we     = dec_o.rs1_rd;
      end
      // lu12i.w and pcaddu12i
      6'b000101, 6'b000111:
      begin
        if (!inst_i[25])
        begin
          dec_o.alu_op = inst_i[27] ? id_pkg::ALU_PCADD : id_pkg::ALU_LUI;
          dec_o.imm    = si20;
          dec_o.we     = 1'b1;
        end
      end
      6'b001010:
      begin
        dec_o.imm = si12;
        case (inst_i[25:22])
          4'b0010:
          begin
            dec_o.alu_op  = id_pkg::ALU_LD_W;
            dec_o.rs1_rd  = 1'b1;
            dec_o.we      = 1'b1;
            dec_o.is_load = 1'b1;
          end
          // Store data comes from rd
          4'b0110:
          begin
            dec_o.alu_op   = id_pkg::ALU_ST_W;
            dec_o.rs1_rd   = 1'b1;
            dec_o.rs2_rd   = 1'b1;
            dec_o.rs2_addr = rd;
          end
          default: dec_o.alu_op = id_pkg::ALU_NOP;
        endcase
      end
      // jirl
      6'b010011:
      begin
        dec_o.alu_op  = id_pkg::ALU_JUMP;
        dec_o.br_cond = id_pkg::BR_REG_REL;
        dec_o.rs1_rd  = 1'b1;
        dec_o.we      = 1'b1;
      end
      6'b010100, 6'b010101:
      begin
        dec_o.alu_op    = id_pkg::ALU_JUMP;
        dec_o.br_cond   = id_pkg::BR_PC_REL;
        dec_o.br_offset = offs26;
        // bl links through r1
        dec_o.we        = inst_i[26];
        dec_o.waddr     = `REG_AW'(`LINK_REG);
      end
      6'b010110, 6'b010111, 6'b011000, 6'b011001, 6'b011010, 6'b011011:
      begin
        dec_o.alu_op   = id_pkg::ALU_JUMP;
        dec_o.rs1_rd   = 1'b1;
        dec_o.rs2_rd   = 1'b1;
        dec_o.rs2_addr = rd;
        case (inst_i[28:26])
          3'b110: dec_o.br_cond = id_pkg::BR_EQ;
          3'b111: dec_o.br_cond = id_pkg::BR_NE;
          3'b000: dec_o.br_cond = id_pkg::BR_LT;
          3'b001: dec_o.br_cond = id_pkg::BR_GE;
          3'b010: dec_o.br_cond = id_pkg::BR_LTU;
          default: dec_o.br_cond = id_pkg::BR_GEU;
        endcase
      end
      default: dec_o.alu_op = id_pkg::ALU_NOP;
    endcase
    dec_o.alu_sel = sel_of(dec_o.alu_op);
    if (dec_o.waddr == '0)
      dec_o.we = 1'b0;
  end

endmodule

`default_nettype wire

// ==== rtl/operand_bypass.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module operand_bypass (
  input  id_pkg::dec_t      dec_i,
  input  logic [`XLEN-1:0]  rdata1_i,
  input  logic [`XLEN-1:0]  rdata2_i,
  input  id_pkg::ex_fwd_t   ex_fwd_i,
  input  id_pkg::wr_port_t  mem_fwd_i,
  input  logic              inst_valid_i,
  output logic [`XLEN-1:0]  src1_o,
  output logic [`XLEN-1:0]  src2_o,
  output logic              hazard_o
);

  logic ex_hit1;
  logic ex_hit2;

  function automatic logic hits(input id_pkg::wr_port_t wr, input logic [`REG_AW-1:0] addr);
    return wr.we && (wr.waddr == addr) && (addr != '0);
  endfunction

  // Youngest write wins
  function automatic logic [`XLEN-1:0] pick(input logic [`REG_AW-1:0] addr,
                                             input logic [`XLEN-1:0]  rf_data,
                                             input id_pkg::ex_fwd_t   ex_fwd,
                                             input id_pkg::wr_port_t  mem_fwd);
    if (hits(ex_fwd.wr, addr))
      return ex_fwd.wr.wdata;
    else if (hits(mem_fwd, addr))
      return mem_fwd.wdata;
    else
      return rf_data;
  endfunction

  assign src1_o = dec_i.rs1_rd ? pick(dec_i.rs1_addr, rdata1_i, ex_fwd_i, mem_fwd_i) : rdata1_i;
  assign src2_o = dec_i.rs2_rd ? pick(dec_i.rs2_addr, rdata2_i, ex_fwd_i, mem_fwd_i) : rdata2_i;

  assign ex_hit1 = dec_i.rs1_rd && hits(ex_fwd_i.wr, dec_i.rs1_addr);
  assign ex_hit2 = dec_i.rs2_rd && hits(ex_fwd_i.wr, dec_i.rs2_addr);

  // Load data is not ready until memory
  assign hazard_o = inst_valid_i && ex_fwd_i.is_load && (ex_hit1 || ex_hit2);

  always_comb
  begin
    a_no_fwd_r0: assert final (
      !(ex_fwd_i.wr.we === 1'b1 && ex_fwd_i.wr.waddr === '0) &&
      !(mem_fwd_i.we === 1'b1 && mem_fwd_i.waddr === '0)
    ) else $error("forwarding write targets r0");
  end

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "id_defs.svh"

module regfile (
  input  logic                clk,
  input  logic                arst_n_i,
  input  id_pkg::wr_port_t    wb_i,
  input  logic [`REG_AW-1:0]  raddr1_i,
  input  logic [`REG_AW-1:0]  raddr2_i,
  output logic [`XLEN-1:0]    rdata1_o,
  output logic [`XLEN-1:0]    rdata2_o
);

  logic [`XLEN-1:0] regs_q [`NUM_REGS];
  logic             wr_en;

  // r0 is hardwired to zero
  assign wr_en = wb_i.we && (wb_i.waddr != '0);

  always_ff @(posedge clk or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs_q[i] <= '0;
    end
    else if (wr_en)
    begin
      regs_q[wb_i.waddr] <= wb_i.wdata;
    end
  end

  // Writeback data seen in the same cycle
  assign rdata1_o = (wr_en && wb_i.waddr == raddr1_i) ? wb_i.wdata : regs_q[raddr1_i];
  assign rdata2_o = (wr_en && wb_i.waddr == raddr2_i) ? wb_i.wdata : regs_q[raddr2_i];

  a_wb_addr_known: assert property (
    @(posedge clk) disable iff (!arst_n_i)
    wb_i.we |-> !$isunknown(wb_i.waddr)
  ) else $error("writeback with unknown address");

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/id_pkg.sv
rtl/regfile.sv
rtl/inst_decoder.sv
rtl/operand_bypass.sv
rtl/branch_unit.sv
rtl/id_ex_reg.sv
rtl/id_stage.sv
bench/tb_id_stage.sv
